// File: perf_event_sampler.sv
// All strobes are taken as synchronous to i_clk_status; two register stages on the
// status path, so events reach the counters two edges after sampling
`timescale 1ns/1ps

module perf_event_sampler
   import perf_pkg::*;
(
   input  logic      i_clk_status,
   input  logic      perf_count_rst,
   input  logic      i_tx_valid,
   input  logic      i_tx_ready,
   input  logic      i_tx_sop,
   input  logic      i_tx_eop,
   input  logic      i_rx_valid,
   input  logic      i_rx_sop,
   input  logic      i_rx_eop,
   input  rx_error_t i_rx_error,
   output logic      o_tx_sop_fire,
   output logic      o_tx_eop_fire,
   output logic      o_rx_sop_fire,
   output logic      o_rx_eop_fire,
   output logic      o_rx_eop_good
);

   logic [3:0] tx_s1, tx_s2;   // {valid, ready, sop, eop}
   logic [2:0] rx_s1, rx_s2;   // {valid, sop, eop}
   rx_error_t  rx_err_s1, rx_err_s2;
   logic       tx_hs;

   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst) begin
         tx_s1 <= '0;
         tx_s2 <= '0;
         rx_s1 <= '0;
         rx_s2 <= '0;
      end else begin
         tx_s1 <= {i_tx_valid, i_tx_ready, i_tx_sop, i_tx_eop};
         tx_s2 <= tx_s1;
         rx_s1 <= {i_rx_valid, i_rx_sop, i_rx_eop};
         rx_s2 <= rx_s1;
      end
   end

   // Error flags only matter alongside a valid eop
   always_ff @(posedge i_clk_status) begin
      rx_err_s1 <= i_rx_error;
      rx_err_s2 <= rx_err_s1;
   end

   assign tx_hs = tx_s2[3] & tx_s2[2];   // Valid and ready

   assign o_tx_sop_fire = tx_hs & tx_s2[1];
   assign o_tx_eop_fire = tx_hs & tx_s2[0];
   assign o_rx_sop_fire = rx_s2[2] & rx_s2[1];
   assign o_rx_eop_fire = rx_s2[2] & rx_s2[0];
   assign o_rx_eop_good = o_rx_eop_fire & (rx_err_s2 == '0);

endmodule

// File: perf_monitor_top.sv
// Single status clock; TX and RX strobes must already be synchronous to it
`timescale 1ns/1ps

module perf_monitor_top
   import perf_pkg::*;
(
   input  logic      i_clk_status,
   input  logic      perf_count_rst,
   input  logic      i_tx_valid,
   input  logic      i_tx_ready,
   input  logic      i_tx_sop,
   input  logic      i_tx_eop,
   input  logic      i_rx_valid,
   input  logic      i_rx_sop,
   input  logic      i_rx_eop,
   input  rx_error_t i_rx_error,
   input  bus_addr_t i_status_addr,
   input  logic      i_status_read,
   input  logic      i_status_write,
   input  reg_data_t i_status_writedata,
   output reg_data_t o_status_readdata,
   output logic      o_status_readdata_valid,
   output logic      o_gen_idle,
   output logic      o_loopback_sel
);

   logic      tx_sop_fire, tx_eop_fire;
   logic      rx_sop_fire, rx_eop_fire, rx_eop_good;
   logic      count_clear;
   logic      stall;
   stat_cnt_t tx_pkt_cnt, rx_pkt_cnt, rx_good_cnt;
   stat_cnt_t tx_start_ts, tx_end_ts, rx_start_ts, rx_end_ts;

   perf_event_sampler u_sampler (
      .i_clk_status   (i_clk_status),
      .perf_count_rst (perf_count_rst),
      .i_tx_valid     (i_tx_valid),
      .i_tx_ready     (i_tx_ready),
      .i_tx_sop       (i_tx_sop),
      .i_tx_eop       (i_tx_eop),
      .i_rx_valid     (i_rx_valid),
      .i_rx_sop       (i_rx_sop),
      .i_rx_eop       (i_rx_eop),
      .i_rx_error     (i_rx_error),
      .o_tx_sop_fire  (tx_sop_fire),
      .o_tx_eop_fire  (tx_eop_fire),
      .o_rx_sop_fire  (rx_sop_fire),
      .o_rx_eop_fire  (rx_eop_fire),
      .o_rx_eop_good  (rx_eop_good)
   );

   perf_pkt_counters u_counters (
      .i_clk_status   (i_clk_status),
      .perf_count_rst (perf_count_rst),
      .i_count_clear  (count_clear),
      .i_stall        (stall),
      .i_tx_eop_fire  (tx_eop_fire),
      .i_rx_eop_fire  (rx_eop_fire),
      .i_rx_eop_good  (rx_eop_good),
      .o_tx_pkt_cnt   (tx_pkt_cnt),
      .o_rx_pkt_cnt   (rx_pkt_cnt),
      .o_rx_good_cnt  (rx_good_cnt)
   );

   perf_timestamps u_timestamps (
      .i_clk_status   (i_clk_status),
      .perf_count_rst (perf_count_rst),
      .i_count_clear  (count_clear),
      .i_stall        (stall),
      .i_tx_sop_fire  (tx_sop_fire),
      .i_tx_eop_fire  (tx_eop_fire),
      .i_rx_sop_fire  (rx_sop_fire),
      .i_rx_eop_fire  (rx_eop_fire),
      .o_tx_start_ts  (tx_start_ts),
      .o_tx_end_ts    (tx_end_ts),
      .o_rx_start_ts  (rx_start_ts),
      .o_rx_end_ts    (rx_end_ts)
   );

   perf_status_regs u_regs (
      .i_clk_status            (i_clk_status),
      .perf_count_rst          (perf_count_rst),
      .i_status_addr           (i_status_addr),
      .i_status_read           (i_status_read),
      .i_status_write          (i_status_write),
      .i_status_writedata      (i_status_writedata),
      .i_tx_pkt_cnt            (tx_pkt_cnt),
      .i_rx_pkt_cnt            (rx_pkt_cnt),
      .i_rx_good_cnt           (rx_good_cnt),
      .i_tx_start_ts           (tx_start_ts),
      .i_tx_end_ts             (tx_end_ts),
      .i_rx_start_ts           (rx_start_ts),
      .i_rx_end_ts             (rx_end_ts),
      .o_status_readdata       (o_status_readdata),
      .o_status_readdata_valid (o_status_readdata_valid),
      .o_count_clear           (count_clear),
      .o_stall                 (stall),
      .o_gen_idle              (o_gen_idle),
      .o_loopback_sel          (o_loopback_sel)
   );

endmodule

// File: perf_pkg.sv
// Widths, register map and fixed read values of the status-clock performance monitor
// The block answers at 0x1000 to 0x103F on the status bus
package perf_pkg;

   localparam int STAT_CNT_W   = 64;
   localparam int REG_DATA_W   = 32;
   localparam int BUS_ADDR_W   = 16;
   localparam int REG_OFFSET_W = 6;
   localparam int RX_ERROR_W   = 6;

   typedef logic [STAT_CNT_W-1:0]   stat_cnt_t;
   typedef logic [REG_DATA_W-1:0]   reg_data_t;
   typedef logic [BUS_ADDR_W-1:0]   bus_addr_t;
   typedef logic [REG_OFFSET_W-1:0] reg_offset_t;
   typedef logic [RX_ERROR_W-1:0]   rx_error_t;

   // Upper ten address bits of base 0x1000
   localparam logic [BUS_ADDR_W-REG_OFFSET_W-1:0] STATUS_ADDR_PREFIX = 10'h040;

   ////////////////////////////////////////
   // Register offsets
   ////////////////////////////////////////
   localparam reg_offset_t OFS_SCRATCH     = 6'h00;
   localparam reg_offset_t OFS_ID          = 6'h01;
   localparam reg_offset_t OFS_CTRL        = 6'h10;
   localparam reg_offset_t OFS_LOG_CTRL    = 6'h18;
   localparam reg_offset_t OFS_TX_CNT_LO   = 6'h19;
   localparam reg_offset_t OFS_TX_CNT_HI   = 6'h1A;
   localparam reg_offset_t OFS_RX_CNT_LO   = 6'h1B;
   localparam reg_offset_t OFS_RX_CNT_HI   = 6'h1C;
   localparam reg_offset_t OFS_RX_GOOD_LO  = 6'h1D;
   localparam reg_offset_t OFS_RX_GOOD_HI  = 6'h1E;
   localparam reg_offset_t OFS_TX_START_LO = 6'h1F;
   localparam reg_offset_t OFS_TX_START_HI = 6'h20;
   localparam reg_offset_t OFS_TX_END_LO   = 6'h21;
   localparam reg_offset_t OFS_TX_END_HI   = 6'h22;
   localparam reg_offset_t OFS_RX_START_LO = 6'h23;
   localparam reg_offset_t OFS_RX_START_HI = 6'h24;
   localparam reg_offset_t OFS_RX_END_LO   = 6'h25;
   localparam reg_offset_t OFS_RX_END_HI   = 6'h26;

   localparam reg_data_t CLIENT_ID     = 32'h434C4E54; // "CLNT"
   localparam reg_data_t BAD_ADDR_DATA = 32'h0BADF00D;
   localparam reg_data_t UNMAPPED_DATA = 32'h00000123;

   localparam int CTRL_IDLE_BIT     = 1;
   localparam int CTRL_LOOPBACK_BIT = 3;

endpackage

// File: perf_pkt_counters.sv
// Live counters keep running while stall holds the snapshot outputs
`timescale 1ns/1ps

module perf_pkt_counters
   import perf_pkg::*;
(
   input  logic      i_clk_status,
   input  logic      perf_count_rst,
   input  logic      i_count_clear,
   input  logic      i_stall,
   input  logic      i_tx_eop_fire,
   input  logic      i_rx_eop_fire,
   input  logic      i_rx_eop_good,
   output stat_cnt_t o_tx_pkt_cnt,
   output stat_cnt_t o_rx_pkt_cnt,
   output stat_cnt_t o_rx_good_cnt
);

   stat_cnt_t tx_cnt;
   stat_cnt_t rx_cnt;
   stat_cnt_t rx_good_cnt;

   ////////////////////////////////////////
   // Live counters
   ////////////////////////////////////////
   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst || i_count_clear) begin
         tx_cnt      <= '0;
         rx_cnt      <= '0;
         rx_good_cnt <= '0;
      end else begin
         if (i_tx_eop_fire) begin
            tx_cnt <= tx_cnt + 1'b1;
         end
         if (i_rx_eop_fire) begin
            rx_cnt <= rx_cnt + 1'b1;
         end
         if (i_rx_eop_good) begin   // Error-free subset of rx eops
            rx_good_cnt <= rx_good_cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Snapshot for the register bus
   ////////////////////////////////////////
   always_ff @(posedge i_clk_status) begin
      if (!i_stall) begin
         o_tx_pkt_cnt  <= tx_cnt;
         o_rx_pkt_cnt  <= rx_cnt;
         o_rx_good_cnt <= rx_good_cnt;
      end
   end

endmodule

// File: perf_status_regs.sv
// Bus strobes are one cycle; reads answer two edges after the strobe, misses included.
// A fall of the idle bit with loopback low clears all counters
`timescale 1ns/1ps

module perf_status_regs
   import perf_pkg::*;
(
   input  logic      i_clk_status,
   input  logic      perf_count_rst,
   input  bus_addr_t i_status_addr,
   input  logic      i_status_read,
   input  logic      i_status_write,
   input  reg_data_t i_status_writedata,
   input  stat_cnt_t i_tx_pkt_cnt,
   input  stat_cnt_t i_rx_pkt_cnt,
   input  stat_cnt_t i_rx_good_cnt,
   input  stat_cnt_t i_tx_start_ts,
   input  stat_cnt_t i_tx_end_ts,
   input  stat_cnt_t i_rx_start_ts,
   input  stat_cnt_t i_rx_end_ts,
   output reg_data_t o_status_readdata,
   output logic      o_status_readdata_valid,
   output logic      o_count_clear,
   output logic      o_stall,
   output logic      o_gen_idle,
   output logic      o_loopback_sel
);

   reg_offset_t addr_r;
   logic        addr_sel_r;
   logic        read_r;
   logic        write_r;
   reg_data_t   writedata_r;
   reg_data_t   scratch;
   logic        reset_log;
   logic        idle_d;
   logic        test_start;
   reg_data_t   ctrl_word;
   reg_data_t   rd_word;

   ////////////////////////////////////////
   // Bus capture
   ////////////////////////////////////////
   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst) begin
         read_r  <= 1'b0;
         write_r <= 1'b0;
      end else begin
         read_r  <= i_status_read;
         write_r <= i_status_write;
      end
   end

   always_ff @(posedge i_clk_status) begin
      addr_r      <= i_status_addr[REG_OFFSET_W-1:0];
      addr_sel_r  <= (i_status_addr[BUS_ADDR_W-1:REG_OFFSET_W] == STATUS_ADDR_PREFIX);
      writedata_r <= i_status_writedata;
   end

   ////////////////////////////////////////
   // Writable registers
   ////////////////////////////////////////
   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst) begin
         scratch        <= '0;
         o_gen_idle     <= 1'b1;   // Generator parked
         o_loopback_sel <= 1'b0;
         o_stall        <= 1'b0;
         reset_log      <= 1'b0;
      end else if (write_r && addr_sel_r) begin
         case (addr_r)
            OFS_SCRATCH:  scratch <= writedata_r;
            OFS_CTRL: begin
               o_gen_idle     <= writedata_r[CTRL_IDLE_BIT];
               o_loopback_sel <= writedata_r[CTRL_LOOPBACK_BIT];
            end
            OFS_LOG_CTRL: {o_stall, reset_log} <= writedata_r[1:0];
            default: ;
         endcase
      end
   end

   // Test start on idle falling edge
   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst) begin
         idle_d <= 1'b1;
      end else begin
         idle_d <= o_gen_idle;
      end
   end

   assign test_start = idle_d & ~o_gen_idle & ~o_loopback_sel;

   always_ff @(posedge i_clk_status) begin
      o_count_clear <= perf_count_rst | reset_log | test_start;
   end

   ////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////
   always_comb begin
      ctrl_word                    = '0;
      ctrl_word[CTRL_IDLE_BIT]     = o_gen_idle;
      ctrl_word[CTRL_LOOPBACK_BIT] = o_loopback_sel;
   end

   always_comb begin
      case (addr_r)
         OFS_SCRATCH:     rd_word = scratch;
         OFS_ID:          rd_word = CLIENT_ID;
         OFS_CTRL:        rd_word = ctrl_word;
         OFS_LOG_CTRL:    rd_word = {30'd0, o_stall, reset_log};
         OFS_TX_CNT_LO:   rd_word = i_tx_pkt_cnt[31:0];
         OFS_TX_CNT_HI:   rd_word = i_tx_pkt_cnt[63:32];
         OFS_RX_CNT_LO:   rd_word = i_rx_pkt_cnt[31:0];
         OFS_RX_CNT_HI:   rd_word = i_rx_pkt_cnt[63:32];
         OFS_RX_GOOD_LO:  rd_word = i_rx_good_cnt[31:0];
         OFS_RX_GOOD_HI:  rd_word = i_rx_good_cnt[63:32];
         OFS_TX_START_LO: rd_word = i_tx_start_ts[31:0];
         OFS_TX_START_HI: rd_word = i_tx_start_ts[63:32];
         OFS_TX_END_LO:   rd_word = i_tx_end_ts[31:0];
         OFS_TX_END_HI:   rd_word = i_tx_end_ts[63:32];
         OFS_RX_START_LO: rd_word = i_rx_start_ts[31:0];
         OFS_RX_START_HI: rd_word = i_rx_start_ts[63:32];
         OFS_RX_END_LO:   rd_word = i_rx_end_ts[31:0];
         OFS_RX_END_HI:   rd_word = i_rx_end_ts[63:32];
         default:         rd_word = UNMAPPED_DATA;
      endcase
   end

   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst) begin
         o_status_readdata_valid <= 1'b0;
      end else begin
         o_status_readdata_valid <= read_r;
      end
   end

   // Holds between reads
   always_ff @(posedge i_clk_status) begin
      if (read_r) begin
         o_status_readdata <= addr_sel_r ? rd_word : BAD_ADDR_DATA;
      end
   end

endmodule

// File: perf_timestamps.sv
// Start stamps track the counter until the first sop after a clear, then freeze;
// end stamps follow every eop, so they hold the last one
`timescale 1ns/1ps

module perf_timestamps
   import perf_pkg::*;
(
   input  logic      i_clk_status,
   input  logic      perf_count_rst,
   input  logic      i_count_clear,
   input  logic      i_stall,
   input  logic      i_tx_sop_fire,
   input  logic      i_tx_eop_fire,
   input  logic      i_rx_sop_fire,
   input  logic      i_rx_eop_fire,
   output stat_cnt_t o_tx_start_ts,
   output stat_cnt_t o_tx_end_ts,
   output stat_cnt_t o_rx_start_ts,
   output stat_cnt_t o_rx_end_ts
);

   // Index 0 is TX, index 1 is RX
   stat_cnt_t  ts_cnt;
   stat_cnt_t  start_ts   [2];
   stat_cnt_t  end_ts     [2];
   stat_cnt_t  snap_start [2];
   stat_cnt_t  snap_end   [2];
   logic [1:0] start_logged;
   logic [1:0] sop_fire;
   logic [1:0] eop_fire;

   assign sop_fire = {i_rx_sop_fire, i_tx_sop_fire};
   assign eop_fire = {i_rx_eop_fire, i_tx_eop_fire};

   // Free-running, restarts with each test
   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst || i_count_clear) begin
         ts_cnt <= '0;
      end else begin
         ts_cnt <= ts_cnt + 1'b1;
      end
   end

   ////////////////////////////////////////
   // First sop and last eop logging
   ////////////////////////////////////////
   always_ff @(posedge i_clk_status) begin
      if (perf_count_rst || i_count_clear) begin
         start_logged <= '0;
         for (int i = 0; i < 2; i++) begin
            start_ts[i] <= '0;
            end_ts[i]   <= '0;
         end
      end else begin
         for (int i = 0; i < 2; i++) begin
            if (sop_fire[i]) begin
               start_logged[i] <= 1'b1;
            end
            if (!start_logged[i]) begin
               start_ts[i] <= ts_cnt;   // Last load lands on the first sop
            end
            if (eop_fire[i]) begin
               end_ts[i] <= ts_cnt;
            end
         end
      end
   end

   always_ff @(posedge i_clk_status) begin
      if (!i_stall) begin
         snap_start <= start_ts;
         snap_end   <= end_ts;
      end
   end

   assign o_tx_start_ts = snap_start[0];
   assign o_tx_end_ts   = snap_end[0];
   assign o_rx_start_ts = snap_start[1];
   assign o_rx_end_ts   = snap_end[1];

endmodule

// File: project.f
perf_pkg.sv
perf_event_sampler.sv
perf_pkt_counters.sv
perf_timestamps.sv
perf_status_regs.sv
perf_monitor_top.sv
tb_perf_monitor.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_perf_monitor \
   -f project.f --Mdir obj_dir -o sim_perf > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Build failed"
   exit 1
fi

./obj_dir/sim_perf > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "tests failed" sim.log; then
   exit 1
fi
if ! grep -q "all tests passed" sim.log; then
   echo "Simulation ended without a result line"
   exit 1
fi
exit 0

// File: tb_perf_monitor.sv
// Bus reads are checked for a two-edge latency; TX and RX traffic run one after the other.
// Packet lengths and error choices come from a fixed-seed LFSR
`timescale 1ns/1ps

module tb_perf_monitor
   import perf_pkg::*;
();

   logic        i_clk_status;
   logic        perf_count_rst;
   logic        i_tx_valid, i_tx_ready, i_tx_sop, i_tx_eop;
   logic        i_rx_valid, i_rx_sop, i_rx_eop;
   rx_error_t   i_rx_error;
   bus_addr_t   i_status_addr;
   logic        i_status_read, i_status_write;
   reg_data_t   i_status_writedata;
   reg_data_t   o_status_readdata;
   logic        o_status_readdata_valid, o_gen_idle, o_loopback_sel;

   int          errors = 0;
   int          checks = 0;
   logic [31:0] lfsr = 32'he445a412;
   logic [63:0] cyc = '0;
   logic [63:0] exp_tx, exp_rx, exp_good;
   logic [63:0] tx_first, tx_last, rx_first, rx_last;
   logic        tx_seen, rx_seen;
   logic [63:0] stat_rd [7];   // tx, rx, good, tx start, tx end, rx start, rx end

   perf_monitor_top uut (.*);

   initial begin
      i_clk_status = 1'b0;
      forever #5 i_clk_status = ~i_clk_status;
   end

   always @(posedge i_clk_status) cyc <= cyc + 1;

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
   endfunction

   task automatic take_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         val  = {val[30:0], lfsr[0]};
      end
   endtask

   function automatic bus_addr_t reg_addr(input reg_offset_t ofs);
      return {STATUS_ADDR_PREFIX, ofs};
   endfunction

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("Fail %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      end
   endtask

   task automatic bus_write(input reg_offset_t ofs, input reg_data_t data);
      @(posedge i_clk_status);
      i_status_write     <= 1'b1;
      i_status_addr      <= reg_addr(ofs);
      i_status_writedata <= data;
      @(posedge i_clk_status);
      i_status_write <= 1'b0;
      @(posedge i_clk_status);   // Register takes the value here
      @(negedge i_clk_status);
   endtask

   task automatic bus_read(input string name, input bus_addr_t addr,
                           output logic [63:0] data);
      int   edges;
      logic got;
      edges = 0;
      got   = 1'b0;
      @(posedge i_clk_status);
      i_status_read <= 1'b1;
      i_status_addr <= addr;
      while (!got && edges < 20) begin
         @(posedge i_clk_status);
         i_status_read <= 1'b0;
         edges++;
         @(negedge i_clk_status);
         got = o_status_readdata_valid;
      end
      data = {32'd0, o_status_readdata};
      if (!got) begin
         errors++;
         $display("Read of %s got no valid pulse within 20 cycles", name);
      end else begin
         check_value({name, " latency"}, 2, 64'(edges));
         @(negedge i_clk_status);
         check_value({name, " valid width"}, 0, 64'(o_status_readdata_valid));
      end
   endtask

   task automatic read_stats(input string tag);
      logic [63:0] lo;
      logic [63:0] hi;
      for (int i = 0; i < 7; i++) begin
         bus_read({tag, " lo"}, reg_addr(OFS_TX_CNT_LO + reg_offset_t'(2 * i)), lo);
         bus_read({tag, " hi"}, reg_addr(OFS_TX_CNT_HI + reg_offset_t'(2 * i)), hi);
         stat_rd[i] = {hi[31:0], lo[31:0]};
      end
   endtask

   task automatic check_counts(input string tag);
      read_stats(tag);
      check_value({tag, " tx count"}, exp_tx, stat_rd[0]);
      check_value({tag, " rx count"}, exp_rx, stat_rd[1]);
      check_value({tag, " rx good count"}, exp_good, stat_rd[2]);
      check_value({tag, " tx span"}, tx_last - tx_first, stat_rd[4] - stat_rd[3]);
      check_value({tag, " rx span"}, rx_last - rx_first, stat_rd[6] - stat_rd[5]);
   endtask

   task automatic clear_model();
      exp_tx   = '0;
      exp_rx   = '0;
      exp_good = '0;
      tx_first = '0;
      tx_last  = '0;
      rx_first = '0;
      rx_last  = '0;
      tx_seen  = 1'b0;
      rx_seen  = 1'b0;
   endtask

   ////////////////////////////////////////
   // Traffic
   ////////////////////////////////////////
   task automatic send_tx(input int len, input bit eop_ready);
      for (int b = 0; b < len; b++) begin
         @(posedge i_clk_status);
         i_tx_valid <= 1'b1;
         i_tx_ready <= (b == len - 1) ? eop_ready : 1'b1;
         i_tx_sop   <= (b == 0);
         i_tx_eop   <= (b == len - 1);
         if (b == 0 && !tx_seen) begin
            tx_first = cyc;
            tx_seen  = 1'b1;
         end
         if (b == len - 1 && eop_ready) begin
            exp_tx++;
            tx_last = cyc;
         end
      end
      @(posedge i_clk_status);
      i_tx_valid <= 1'b0;
      i_tx_ready <= 1'b0;
      i_tx_sop   <= 1'b0;
      i_tx_eop   <= 1'b0;
   endtask

   task automatic send_rx(input int len, input rx_error_t err);
      for (int b = 0; b < len; b++) begin
         @(posedge i_clk_status);
         i_rx_valid <= 1'b1;
         i_rx_sop   <= (b == 0);
         i_rx_eop   <= (b == len - 1);
         i_rx_error <= (b == len - 1) ? err : '0;
         if (b == 0 && !rx_seen) begin
            rx_first = cyc;
            rx_seen  = 1'b1;
         end
      end
      exp_rx++;
      if (err == '0) begin
         exp_good++;
      end
      rx_last = cyc;
      @(posedge i_clk_status);
      i_rx_valid <= 1'b0;
      i_rx_sop   <= 1'b0;
      i_rx_eop   <= 1'b0;
      i_rx_error <= '0;
   endtask

   task automatic run_traffic(input int npkts);
      int len;
      int pick;
      int errv;
      for (int p = 0; p < npkts; p++) begin
         take_bits(3, len);
         take_bits(2, pick);
         send_tx(len + 2, (p == 0) || (pick != 0));   // First eop always handshaken
      end
      for (int p = 0; p < npkts; p++) begin
         take_bits(3, len);
         take_bits(2, pick);
         take_bits(5, errv);
         send_rx(len + 2, (pick == 0) ? {errv[4:0], 1'b1} : 6'd0);
      end
      repeat (6) @(posedge i_clk_status);   // Drain the event pipeline
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////
   initial begin
      logic [63:0] rd;
      logic [63:0] frozen [7];
      int          n;
      perf_count_rst     = 1'b1;
      i_tx_valid         = 1'b0;
      i_tx_ready         = 1'b0;
      i_tx_sop           = 1'b0;
      i_tx_eop           = 1'b0;
      i_rx_valid         = 1'b0;
      i_rx_sop           = 1'b0;
      i_rx_eop           = 1'b0;
      i_rx_error         = '0;
      i_status_addr      = '0;
      i_status_read      = 1'b0;
      i_status_write     = 1'b0;
      i_status_writedata = '0;
      clear_model();
      repeat (4) @(posedge i_clk_status);
      perf_count_rst <= 1'b0;
      @(negedge i_clk_status);

      // ID, scratch and misses
      bus_read("id", reg_addr(OFS_ID), rd);
      check_value("id", 64'(CLIENT_ID), rd);
      bus_write(OFS_SCRATCH, 32'h5A5AC3C3);
      bus_read("scratch", reg_addr(OFS_SCRATCH), rd);
      check_value("scratch", 64'h5A5AC3C3, rd);
      bus_read("bad addr", 16'h2000, rd);
      check_value("bad addr", 64'(BAD_ADDR_DATA), rd);
      bus_read("unmapped", reg_addr(6'h3F), rd);
      check_value("unmapped", 64'(UNMAPPED_DATA), rd);

      // Control reset values and writes
      bus_read("ctrl reset", reg_addr(OFS_CTRL), rd);
      check_value("ctrl reset", 64'h2, rd);
      check_value("idle after reset", 1, 64'(o_gen_idle));
      check_value("loopback after reset", 0, 64'(o_loopback_sel));
      bus_write(OFS_CTRL, 32'hA);
      check_value("idle out", 1, 64'(o_gen_idle));
      check_value("loopback out", 1, 64'(o_loopback_sel));
      bus_read("ctrl write", reg_addr(OFS_CTRL), rd);
      check_value("ctrl write", 64'hA, rd);
      bus_write(OFS_CTRL, 32'h2);
      check_value("loopback cleared", 0, 64'(o_loopback_sel));

      // Traffic before the test start must be cleared
      send_tx(3, 1'b1);
      send_rx(3, '0);
      bus_write(OFS_CTRL, 32'h0);
      check_value("idle low", 0, 64'(o_gen_idle));
      clear_model();
      repeat (4) @(posedge i_clk_status);
      take_bits(2, n);
      run_traffic(4 + n);
      check_counts("test run");

      // Stall freezes every snapshot
      bus_write(OFS_LOG_CTRL, 32'h2);
      bus_read("log ctrl", reg_addr(OFS_LOG_CTRL), rd);
      check_value("log ctrl", 64'h2, rd);
      read_stats("stall before");
      frozen = stat_rd;
      run_traffic(3);
      read_stats("stall during");
      for (int i = 0; i < 7; i++) begin
         check_value($sformatf("stalled value %0d", i), frozen[i], stat_rd[i]);
      end
      bus_write(OFS_LOG_CTRL, 32'h0);
      repeat (3) @(posedge i_clk_status);
      check_counts("after stall");

      // Reset log holds everything at zero
      bus_write(OFS_LOG_CTRL, 32'h1);
      repeat (2) @(posedge i_clk_status);
      read_stats("reset log");
      for (int i = 0; i < 7; i++) begin
         check_value($sformatf("reset log value %0d", i), 0, stat_rd[i]);
      end
      bus_write(OFS_LOG_CTRL, 32'h0);
      clear_model();
      run_traffic(2);
      check_counts("after reset log");

      // Loopback start keeps the counters
      bus_write(OFS_CTRL, 32'hA);
      bus_write(OFS_CTRL, 32'h8);
      check_value("loopback idle", 0, 64'(o_gen_idle));
      check_value("loopback sel", 1, 64'(o_loopback_sel));
      repeat (4) @(posedge i_clk_status);
      check_counts("loopback start");

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule
